// File: verilog.f
+incdir+src
src/crtc_reg_pkg.sv
src/crtc_raster_pkg.sv
src/crtc_if.sv
src/crtc_regs.sv
src/crtc_raster.sv
src/crtc_addr.sv
src/crtc_top.sv
test/tb_crtc.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the CRTC testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_crtc \
	-f verilog.f -o tb_crtc \
	&& ./obj_dir/tb_crtc > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q '\*\* FAIL \*\*' sim.log \
	&& { echo "simulation failed, see sim.log"; exit 1; } \
	|| echo "simulation passed"

// File: test/tb_crtc.sv
//================================================
// CRTC testbench: register access, raster timing,
// addressing and cursor against a raster model
//================================================
`timescale 1ns/1ns
`include "crtc_cfg.svh"

module tb_crtc;

	logic                  CLOCK = 1'b0;
	logic                  nRESET;
	logic                  bus_en;
	logic                  ncs;
	logic                  r_nw;
	logic                  rs;
	logic [7:0]            di;
	logic [7:0]            do_data;
	logic                  char_en = 1'b0;
	logic                  hsync;
	logic                  vsync;
	logic                  de;
	logic                  cursor;
	logic [`CRTC_MA_W-1:0] ma;
	logic [`CRTC_RA_W-1:0] ra;

	// programmed register values, read by the model
	int  rv [16];
	logic run_en;
	time deadline;
	int  total_errors;
	int  tests_run;
	int  tests_failed;

	// raster model and measurement state
	int   video_errors;
	int   m_hcc;
	int   m_line;
	int   m_row;
	int   lmax;
	logic m_adj;
	logic addr_ok;
	logic wrap;
	logic cur_exp;
	logic hs_prev;
	logic vs_prev;
	logic hs_seen;
	logic vs_seen;
	logic ma_valid;
	int   hs_gap;
	int   hs_wid;
	int   de_cnt;
	int   vs_lines;
	int   vs_wid;
	int   prev_hcc;
	int   prev_ma;
	int   n_hper;
	int   n_hwid;
	int   n_de;
	int   n_vper;
	int   n_vpos;
	int   n_vwid;
	int   n_ma;
	int   n_step;
	int   n_cur;
	int   n_hit;

	crtc_top DUT (
		.CLOCK   (CLOCK),
		.nRESET  (nRESET),
		.bus_en  (bus_en),
		.ncs     (ncs),
		.r_nw    (r_nw),
		.rs      (rs),
		.di      (di),
		.do_data (do_data),
		.char_en (char_en),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de),
		.cursor  (cursor),
		.ma      (ma),
		.ra      (ra)
	);

	always #50 CLOCK = ~CLOCK;

	// about three enabled characters in four
	always @(negedge CLOCK) begin
		char_en = run_en && (($urandom % 4) != 0);
	end

	always @(posedge CLOCK) begin
		if (deadline != 0 && $time > deadline) begin
			$display("timeout: the running test did not finish in time");
			$display("** FAIL **");
			$finish;
		end
	end

	// ================================================
	// checker and raster model
	// ================================================
	task automatic video_fail(input string msg);
		video_errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// outputs seen here still hold the state from before this edge
	always @(posedge CLOCK) begin
		if (!nRESET) begin
			m_hcc = 0;
			m_line = 0;
			m_row = 0;
			m_adj = 1'b0;
			addr_ok = 1'b0;
			hs_prev = 1'b0;
			vs_prev = 1'b0;
			hs_seen = 1'b0;
			vs_seen = 1'b0;
			ma_valid = 1'b0;
			hs_gap = 0;
			hs_wid = 0;
			de_cnt = 0;
			vs_lines = 0;
			vs_wid = 0;
			video_errors = 0;
			n_hper = 0;
			n_hwid = 0;
			n_de = 0;
			n_vper = 0;
			n_vpos = 0;
			n_vwid = 0;
			n_ma = 0;
			n_step = 0;
			n_cur = 0;
			n_hit = 0;
		end else begin
			wrap = char_en && m_hcc == rv[0];
			// horizontal sync spacing and width
			if (hsync && !hs_prev) begin
				if (hs_seen) begin
					n_hper++;
					assert (hs_gap == rv[0] + 1) else
						video_fail($sformatf("hsync period %0d, expected %0d", hs_gap, rv[0] + 1));
				end
				hs_seen = 1'b1;
				hs_gap = 0;
				hs_wid = 0;
				vs_lines++;
			end
			if (!hsync && hs_prev) begin
				n_hwid++;
				assert (hs_wid == rv[3] % 16) else
					video_fail($sformatf("hsync width %0d, expected %0d", hs_wid, rv[3] % 16));
			end
			if (char_en)
				hs_gap++;
			if (hsync && char_en)
				hs_wid++;
			// displayed characters per line
			if (char_en) begin
				if (de)
					de_cnt++;
				if (wrap) begin
					if (!m_adj && m_row < rv[6]) begin
						n_de++;
						assert (de_cnt == rv[1]) else
							video_fail($sformatf("de count %0d, expected %0d", de_cnt, rv[1]));
					end
					de_cnt = 0;
				end
			end
			// vertical sync position, frame length and width
			if (vsync && !vs_prev) begin
				n_vpos++;
				assert (m_row == rv[7] && m_line == 0 && m_hcc == 0 && !m_adj) else
					video_fail($sformatf("vsync rose at row %0d line %0d", m_row, m_line));
				if (vs_seen) begin
					n_vper++;
					assert (vs_lines == (rv[4] + 1) * (rv[9] + 1) + rv[5]) else
						video_fail($sformatf("frame of %0d lines", vs_lines));
				end
				vs_seen = 1'b1;
				vs_lines = 0;
				vs_wid = 0;
			end
			if (!vsync && vs_prev) begin
				n_vwid++;
				assert (vs_wid == ((rv[3] / 16) == 0 ? 16 : rv[3] / 16)) else
					video_fail($sformatf("vsync width %0d lines", vs_wid));
			end
			if (vsync && wrap)
				vs_wid++;
			// memory and row address
			if (de && addr_ok) begin
				if (m_hcc == 0) begin
					n_ma++;
					assert (int'(ma) == (rv[12] * 256 + rv[13] + m_row * rv[1]) % 16384
							&& int'(ra) == m_line) else
						video_fail($sformatf("ma %h ra %0d at row %0d", ma, ra, m_row));
				end else if (ma_valid && m_hcc == prev_hcc + 1) begin
					n_step++;
					assert (int'(ma) == (prev_ma + 1) % 16384) else
						video_fail($sformatf("ma %h after %h", ma, prev_ma));
				end
				prev_hcc = m_hcc;
				prev_ma = int'(ma);
				ma_valid = 1'b1;
			end else begin
				ma_valid = 1'b0;
			end
			// cursor strobe, display and address taken from the model position
			if (addr_ok) begin
				cur_exp = !m_adj && m_row < rv[6] && m_hcc < rv[1]
					&& (rv[12] * 256 + rv[13] + m_row * rv[1] + m_hcc) % 16384
						== rv[14] * 256 + rv[15]
					&& m_line >= rv[10] % 32 && m_line <= rv[11];
				n_cur++;
				if (cursor)
					n_hit++;
				assert (cursor == cur_exp) else
					video_fail($sformatf("cursor %b, expected %b", cursor, cur_exp));
			end
			// advance the model on enabled characters
			if (char_en) begin
				if (m_hcc == rv[0]) begin
					m_hcc = 0;
					lmax = m_adj ? rv[5] - 1 : rv[9];
					if (m_line == lmax) begin
						m_line = 0;
						if (m_adj) begin
							m_adj = 1'b0;
							m_row = 0;
							addr_ok = 1'b1;
						end else if (m_row == rv[4]) begin
							if (rv[5] != 0) begin
								m_adj = 1'b1;
							end else begin
								m_row = 0;
								addr_ok = 1'b1;
							end
						end else begin
							m_row++;
						end
					end else begin
						m_line++;
					end
				end else begin
					m_hcc++;
				end
			end
			hs_prev = hsync;
			vs_prev = vsync;
		end
	end

	// ================================================
	// bus tasks and tests
	// ================================================
	task automatic bus_write(input logic sel_data, input logic [7:0] data);
		@(negedge CLOCK);
		bus_en = 1'b1;
		ncs = 1'b0;
		r_nw = 1'b0;
		rs = sel_data;
		di = data;
		@(negedge CLOCK);
		bus_en = 1'b0;
		ncs = 1'b1;
		r_nw = 1'b1;
	endtask

	task automatic set_reg(input int idx, input int val);
		bus_write(1'b0, 8'(idx));
		bus_write(1'b1, 8'(val));
	endtask

	// chip_sel high selects the device and the read is sampled on the edge
	task automatic read_reg(input int idx, input logic chip_sel, output logic [7:0] data);
		bus_write(1'b0, 8'(idx));
		bus_en = 1'b1;
		ncs = ~chip_sel;
		r_nw = 1'b1;
		rs = 1'b1;
		@(posedge CLOCK);
		data = do_data;
		@(negedge CLOCK);
		bus_en = 1'b0;
		ncs = 1'b1;
	endtask

	task automatic apply_reset();
		@(negedge CLOCK);
		nRESET = 1'b0;
		repeat (10) @(negedge CLOCK);
		nRESET = 1'b1;
	endtask

	task automatic report_test(input string name, input int checks, input int errs);
		tests_run++;
		if (errs != 0)
			tests_failed++;
		total_errors += errs;
		$display("test %s: %0d checks, %0d errors, %s", name, checks, errs,
			errs == 0 ? "passed" : "failed");
	endtask

	task automatic require_reached(input string what, input int count, inout int errs);
		if (count == 0) begin
			$display("the %s check was never reached", what);
			errs++;
		end
	endtask

	task automatic check_register_access();
		logic [7:0] wval [16];
		logic [7:0] got;
		int         i;
		int         errs;
		errs = 0;
		deadline = $time + 64'd60000;
		for (i = 0; i < 16; i++) begin
			wval[i] = 8'($urandom);
			// the start and cursor high bytes hold 6 bits
			if (i == 12 || i == 14)
				wval[i] = wval[i] & 8'h3F;
			set_reg(i, int'(wval[i]));
		end
		for (i = 0; i < 16; i++) begin
			read_reg(i, 1'b1, got);
			assert (got == (i >= 12 ? wval[i] : 8'h00)) else begin
				errs++;
				$display("Error at %0t ns: R%0d read %h", $time, i, got);
			end
		end
		read_reg(12, 1'b0, got);
		assert (got == 8'hFF) else begin
			errs++;
			$display("Error at %0t ns: deselected read %h", $time, got);
		end
		report_test("register_access", 17, errs);
	endtask

	task automatic run_video(input string name, input int r0, input int r1, input int r2,
			input int r3, input int r4, input int r5, input int r6, input int r7,
			input int r9, input int r10, input int r11, input int start,
			input int cur, input logic want_hits);
		int i;
		int errs;
		rv = '{r0, r1, r2, r3, r4, r5, r6, r7, 0, r9, r10, r11,
			start / 256, start % 256, cur / 256, cur % 256};
		// four frames at no more than two cycles per character
		deadline = $time + 64'((4 * (r0 + 1) * ((r4 + 1) * (r9 + 1) + r5) * 2 + 500) * 100);
		apply_reset();
		for (i = 0; i < 16; i++)
			set_reg(i, rv[i]);
		run_en = 1'b1;
		wait (n_vper >= 2);
		@(negedge CLOCK);
		run_en = 1'b0;
		@(negedge CLOCK);
		errs = video_errors;
		require_reached("hsync period", n_hper, errs);
		require_reached("hsync width", n_hwid, errs);
		require_reached("display enable", n_de, errs);
		require_reached("vsync position", n_vpos, errs);
		require_reached("vsync width", n_vwid, errs);
		require_reached("memory address", n_ma, errs);
		require_reached("address step", n_step, errs);
		require_reached("cursor", n_cur, errs);
		if (want_hits)
			require_reached("cursor hit", n_hit, errs);
		report_test(name, n_hper + n_hwid + n_de + n_vper + n_vpos + n_vwid + n_ma
			+ n_step + n_cur, errs);
	endtask

	initial begin
		void'($urandom(32'h2bce));
		nRESET = 1'b0;
		bus_en = 1'b0;
		ncs = 1'b1;
		r_nw = 1'b1;
		rs = 1'b0;
		di = 8'h00;
		run_en = 1'b0;
		deadline = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset();
		check_register_access();
		// cursor window on lines 1 to 2 at row 2, column 5
		run_video("frame_no_adjust", 19, 12, 14, 8'h33, 9, 0, 8, 6, 3, 8'h61, 2,
			16'h0100, 16'h011D, 1'b1);
		// start near the top of memory so ma wraps, window below every row
		run_video("frame_with_adjust", 15, 10, 11, 8'h52, 7, 3, 6, 5, 2, 8'h26, 7,
			16'h3FF0, 16'h3FFD, 1'b0);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: src/crtc_top.sv
//================================================
// CRTC top level: register file, raster timing
// and address generation
//================================================
`timescale 1ns/1ns
`include "crtc_cfg.svh"

module crtc_top (
	input  logic                  CLOCK,
	input  logic                  nRESET,
	// CPU strobe bus
	input  logic                  bus_en,
	input  logic                  ncs,
	input  logic                  r_nw,
	input  logic                  rs,
	input  logic [7:0]            di,
	output logic [7:0]            do_data,
	// character clock enable
	input  logic                  char_en,
	// video outputs
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de,
	output logic                  cursor,
	output logic [`CRTC_MA_W-1:0] ma,
	output logic [`CRTC_RA_W-1:0] ra
);

	crtc_cfg_if    cfg_bus ();
	crtc_raster_if ras_bus ();

	crtc_regs u_regs (
		.CLOCK   (CLOCK),
		.nRESET  (nRESET),
		.bus_en  (bus_en),
		.ncs     (ncs),
		.r_nw    (r_nw),
		.rs      (rs),
		.di      (di),
		.do_data (do_data),
		.cfg     (cfg_bus.src)
	);

	crtc_raster u_raster (
		.CLOCK   (CLOCK),
		.nRESET  (nRESET),
		.char_en (char_en),
		.cfg     (cfg_bus.snk),
		.rst     (ras_bus.src),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de)
	);

	crtc_addr u_addr (
		.CLOCK  (CLOCK),
		.nRESET (nRESET),
		.cfg    (cfg_bus.snk),
		.rst    (ras_bus.snk),
		.ma     (ma),
		.ra     (ra),
		.cursor (cursor)
	);

endmodule

// File: src/crtc_addr.sv
//================================================
// CRTC addressing: MA pointers, RA and cursor
//================================================
`timescale 1ns/1ns
`include "crtc_cfg.svh"

module crtc_addr (
	input  logic                  CLOCK,
	input  logic                  nRESET,
	crtc_cfg_if.snk               cfg,
	crtc_raster_if.snk            rst,
	output logic [`CRTC_MA_W-1:0] ma,
	output logic [`CRTC_RA_W-1:0] ra,
	output logic                  cursor
);

	import crtc_reg_pkg::*;
	import crtc_raster_pkg::*;

	crtc_regs_t            r;
	raster_pos_t           pos;
	raster_evt_t           evt;

	logic [`CRTC_MA_W-1:0] row_ptr;
	logic [`CRTC_MA_W-1:0] run_ptr;
	logic [`CRTC_MA_W-1:0] start_addr;
	logic [`CRTC_MA_W-1:0] cur_addr;
	logic [`CRTC_RA_W-1:0] next_line;
	logic                  cur_line;

	assign r   = cfg.regs;
	assign pos = rst.pos;
	assign evt = rst.evt;

	assign start_addr = {r.start_h, r.start_l};
	assign cur_addr   = {r.cur_h, r.cur_l};

	// ================================================
	// memory address
	// ================================================
	// run_ptr walks the line, row_ptr holds where the row began
	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			row_ptr <= '0;
			run_ptr <= '0;
		end else if (rst.char_en) begin
			if (evt.frame_new) begin
				row_ptr <= start_addr;
				run_ptr <= start_addr;
			end else begin
				if (evt.row_save)
					row_ptr <= run_ptr;
				// a save on the wrap itself keeps the pointer where it is
				if (!evt.line_new)
					run_ptr <= run_ptr + 1'b1;
				else if (!evt.row_save)
					run_ptr <= row_ptr;
			end
		end
	end

	assign ma = run_ptr;
	assign ra = pos.line;

	// ================================================
	// cursor
	// ================================================
	assign next_line = evt.row_new ? '0 : pos.line + 1'b1;

	// window opens entering the start line and closes after the end line
	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			cur_line <= 1'b0;
		end else if (evt.line_new) begin
			if (next_line == r.cur_start)
				cur_line <= 1'b1;
			else if (pos.line == r.cur_end)
				cur_line <= 1'b0;
		end
	end

	assign cursor = rst.hde & rst.vde & cur_line & (ma == cur_addr);

endmodule

// File: src/crtc_raster.sv
//================================================
// CRTC raster timing: counters, vertical adjust,
// horizontal and vertical sync, display enable
//================================================
`timescale 1ns/1ns
`include "crtc_cfg.svh"

module crtc_raster (
	input  logic       CLOCK,
	input  logic       nRESET,
	input  logic       char_en,
	crtc_cfg_if.snk    cfg,
	crtc_raster_if.src rst,
	output logic       hsync,
	output logic       vsync,
	output logic       de
);

	import crtc_reg_pkg::*;
	import crtc_raster_pkg::*;

	crtc_regs_t            r;
	raster_pos_t           pos;
	raster_evt_t           evt;

	logic [7:0]            hcc;
	logic [`CRTC_RA_W-1:0] line;
	logic [6:0]            row;
	logic                  in_adj;

	logic                  hcc_last;
	logic [`CRTC_RA_W-1:0] line_max;
	logic                  line_last;
	logic                  row_last;
	logic                  adj_start;
	logic [6:0]            row_nxt;

	logic [3:0]            hsc;
	logic [3:0]            vsc;
	logic                  vsync_allow;
	logic                  hde;
	logic                  vde;

	assign r = cfg.regs;

	// ================================================
	// counter decode
	// ================================================
	assign hcc_last  = hcc == r.h_total;
	// adjust lines count 0 .. R5-1 with the line counter
	assign line_max  = in_adj ? r.v_adj - 5'd1 : r.max_line;
	assign line_last = line == line_max;
	assign row_last  = row == r.v_total;

	assign evt.line_new  = char_en & hcc_last;
	assign evt.row_new   = evt.line_new & line_last;
	assign adj_start     = evt.row_new & ~in_adj & row_last & (r.v_adj != 5'd0);
	assign evt.frame_new = evt.row_new & (in_adj | (row_last & (r.v_adj == 5'd0)));
	assign evt.row_save  = char_en & line_last & (hcc == r.h_disp);

	// row holds at R4 through the adjust lines
	always_comb begin
		if (evt.frame_new)
			row_nxt = 7'd0;
		else if (in_adj || adj_start)
			row_nxt = row;
		else
			row_nxt = row + 7'd1;
	end

	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			hcc    <= '0;
			line   <= '0;
			row    <= '0;
			in_adj <= 1'b0;
		end else if (char_en) begin
			hcc <= hcc_last ? 8'd0 : hcc + 8'd1;
			if (hcc_last)
				line <= line_last ? '0 : line + 1'b1;
			if (evt.row_new) begin
				row <= row_nxt;
				if (adj_start)
					in_adj <= 1'b1;
				else if (evt.frame_new)
					in_adj <= 1'b0;
			end
		end
	end

	// ================================================
	// sync generation
	// ================================================
	// hsync starts on the character after R2, width of zero gives none
	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			hsync <= 1'b0;
			hsc   <= '0;
		end else if (char_en) begin
			if (hsync) begin
				if (hsc == r.h_sw)
					hsync <= 1'b0;
				else
					hsc <= hsc + 4'd1;
			end else if (hcc == r.h_spos && r.h_sw != 4'd0) begin
				hsync <= 1'b1;
				hsc   <= 4'd1;
			end
		end
	end

	// vsync counts down in lines, width 0 wraps to 16
	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			vsync       <= 1'b0;
			vsc         <= '0;
			vsync_allow <= 1'b1;
		end else if (evt.line_new) begin
			// re-arm only when the row really moves on
			if (evt.row_new && row_nxt != row)
				vsync_allow <= 1'b1;
			if (vsc != 4'd0) begin
				vsc <= vsc - 4'd1;
			end else if (vsync_allow && evt.row_new && row_nxt == r.v_spos) begin
				vsync       <= 1'b1;
				vsync_allow <= 1'b0;
				vsc         <= r.v_sw - 4'd1;
			end else begin
				vsync <= 1'b0;
			end
		end
	end

	// display enable
	assign hde = hcc < r.h_disp;
	assign vde = ~in_adj & (row < r.v_disp);
	assign de  = hde & vde;

	always_comb begin
		pos.hcc    = hcc;
		pos.line   = line;
		pos.row    = row;
		pos.in_adj = in_adj;
	end

	assign rst.pos     = pos;
	assign rst.evt     = evt;
	assign rst.char_en = char_en;
	assign rst.hde     = hde;
	assign rst.vde     = vde;

endmodule

// File: src/crtc_regs.sv
//================================================
// CRTC register file: CPU strobe bus, address
// register, sixteen registers and read mux
//================================================
`timescale 1ns/1ns
`include "crtc_cfg.svh"

module crtc_regs (
	input  logic       CLOCK,
	input  logic       nRESET,
	input  logic       bus_en,
	input  logic       ncs,
	input  logic       r_nw,
	input  logic       rs,
	input  logic [7:0] di,
	output logic [7:0] do_data,
	crtc_cfg_if.src    cfg
);

	import crtc_reg_pkg::*;

	localparam int NREG = `CRTC_NREGS;

	logic [4:0]  addr_q;
	crtc_regs_t  regs_q;
	crtc_wdata_u wd;
	logic        sel;
	logic        wr;
	logic        in_range;

	assign sel      = bus_en & ~ncs;
	assign wr       = sel & ~r_nw;
	assign in_range = int'(addr_q) < NREG;
	assign wd.raw   = di;

	// ================================================
	// write side
	// ================================================
	always_ff @(posedge CLOCK) begin
		if (!nRESET) begin
			addr_q <= '0;
			regs_q <= '0;
		end else if (wr) begin
			if (!rs) begin
				addr_q <= di[4:0];
			end else if (in_range) begin
				case (addr_q[3:0])
					`CRTC_R_HTOT:  regs_q.h_total <= wd.raw;
					`CRTC_R_HDISP: regs_q.h_disp  <= wd.raw;
					`CRTC_R_HSPOS: regs_q.h_spos  <= wd.raw;
					`CRTC_R_SYNCW: begin
						regs_q.v_sw <= wd.r3.vsw;
						regs_q.h_sw <= wd.r3.hsw;
					end
					`CRTC_R_VTOT:  regs_q.v_total <= wd.raw[6:0];
					`CRTC_R_VADJ:  regs_q.v_adj   <= wd.raw[4:0];
					`CRTC_R_VDISP: regs_q.v_disp  <= wd.raw[6:0];
					`CRTC_R_VSPOS: regs_q.v_spos  <= wd.raw[6:0];
					`CRTC_R_MODE: begin
						regs_q.skew  <= wd.raw[5:4];
						regs_q.ilace <= wd.raw[1:0];
					end
					`CRTC_R_MAXL:  regs_q.max_line <= wd.raw[4:0];
					`CRTC_R_CURS: begin
						regs_q.cur_mode  <= wd.r10.mode;
						regs_q.cur_start <= wd.r10.start;
					end
					`CRTC_R_CURE:  regs_q.cur_end <= wd.raw[4:0];
					`CRTC_R_STAH:  regs_q.start_h <= wd.raw[5:0];
					`CRTC_R_STAL:  regs_q.start_l <= wd.raw;
					`CRTC_R_CURH:  regs_q.cur_h   <= wd.raw[5:0];
					`CRTC_R_CURL:  regs_q.cur_l   <= wd.raw;
					default: ;
				endcase
			end
		end
	end

	assign cfg.regs = regs_q;

	// ================================================
	// read side
	// ================================================
	// only the address registers read back, status reads as FF
	always_comb begin
		do_data = 8'hFF;
		if (sel && rs) begin
			do_data = 8'h00;
			if (in_range) begin
				case (addr_q[3:0])
					`CRTC_R_STAH: do_data = {2'b00, regs_q.start_h};
					`CRTC_R_STAL: do_data = regs_q.start_l;
					`CRTC_R_CURH: do_data = {2'b00, regs_q.cur_h};
					`CRTC_R_CURL: do_data = regs_q.cur_l;
					default:      do_data = 8'h00;
				endcase
			end
		end
	end

endmodule

// File: src/crtc_if.sv
//================================================
// CRTC internal buses: register set and raster
//================================================
`timescale 1ns/1ns

// programmed registers from the CPU side to the timing blocks
interface crtc_cfg_if;

	crtc_reg_pkg::crtc_regs_t regs;

	modport src (
		output regs
	);

	modport snk (
		input regs
	);

endinterface

// raster state from the counter block to the address block
interface crtc_raster_if;

	crtc_raster_pkg::raster_pos_t pos;
	crtc_raster_pkg::raster_evt_t evt;
	logic                         char_en;
	// the two halves of display enable
	logic                         hde;
	logic                         vde;

	modport src (
		output pos,
		output evt,
		output char_en,
		output hde,
		output vde
	);

	modport snk (
		input pos,
		input evt,
		input char_en,
		input hde,
		input vde
	);

endinterface

// File: src/crtc_raster_pkg.sv
//================================================
// CRTC raster types: beam position and events
//================================================
`include "crtc_cfg.svh"

package crtc_raster_pkg;

	// current character position in the frame
	typedef struct packed {
		logic [7:0]            hcc;
		logic [`CRTC_RA_W-1:0] line;
		logic [6:0]            row;
		// set during the vertical adjust lines
		logic                  in_adj;
	} raster_pos_t;

	// one-cycle flags, already qualified by the character enable
	typedef struct packed {
		// horizontal counter wraps
		logic line_new;
		// last line of a row ends
		logic row_new;
		// last line of the frame ends
		logic frame_new;
		// row start pointer is captured
		logic row_save;
	} raster_evt_t;

endpackage

// File: src/crtc_reg_pkg.sv
//================================================
// CRTC register types: programmed set and the
// CPU write byte with its per-register views
//================================================
`include "crtc_cfg.svh"

package crtc_reg_pkg;

	// all programmed fields, each at its implemented width
	typedef struct packed {
		logic [7:0]            h_total;
		logic [7:0]            h_disp;
		logic [7:0]            h_spos;
		logic [3:0]            v_sw;
		logic [3:0]            h_sw;
		logic [6:0]            v_total;
		logic [4:0]            v_adj;
		logic [6:0]            v_disp;
		logic [6:0]            v_spos;
		// mode bits, stored only
		logic [1:0]            skew;
		logic [1:0]            ilace;
		logic [`CRTC_RA_W-1:0] max_line;
		// blink mode is kept but has no effect
		logic [1:0]            cur_mode;
		logic [`CRTC_RA_W-1:0] cur_start;
		logic [`CRTC_RA_W-1:0] cur_end;
		logic [5:0]            start_h;
		logic [7:0]            start_l;
		logic [5:0]            cur_h;
		logic [7:0]            cur_l;
	} crtc_regs_t;

	// R3 packs both sync widths into one byte
	typedef struct packed {
		logic [3:0] vsw;
		logic [3:0] hsw;
	} wdata_r3_t;

	// R10 carries blink mode and cursor start line
	typedef struct packed {
		logic       pad;
		logic [1:0] mode;
		logic [4:0] start;
	} wdata_r10_t;

	typedef union packed {
		logic [7:0] raw;
		wdata_r3_t  r3;
		wdata_r10_t r10;
	} crtc_wdata_u;

endpackage

// File: src/crtc_cfg.svh
//================================================
// CRTC configuration: bus widths and register map
//================================================
`ifndef CRTC_CFG_SVH
`define CRTC_CFG_SVH

// video address and row address widths
`define CRTC_MA_W 14
`define CRTC_RA_W 5

// programmable register count
`define CRTC_NREGS 16

// register indices, as selected by the address register
`define CRTC_R_HTOT  4'd0
`define CRTC_R_HDISP 4'd1
`define CRTC_R_HSPOS 4'd2
`define CRTC_R_SYNCW 4'd3
`define CRTC_R_VTOT  4'd4
`define CRTC_R_VADJ  4'd5
`define CRTC_R_VDISP 4'd6
`define CRTC_R_VSPOS 4'd7
`define CRTC_R_MODE  4'd8
`define CRTC_R_MAXL  4'd9
`define CRTC_R_CURS  4'd10
`define CRTC_R_CURE  4'd11
`define CRTC_R_STAH  4'd12
`define CRTC_R_STAL  4'd13
`define CRTC_R_CURH  4'd14
`define CRTC_R_CURL  4'd15

`endif
